//--- Makefile
# Verilator build and run for the CRTC register front end.

SIM = obj_dir/crt_tb_sim

.PHONY: compile run clean

compile: $(SIM)

$(SIM): vga_crt.f verilog/*.sv tests/*.sv
	verilator --binary --timing --assert -j 0 --top-module crt_tb -f vga_crt.f -o crt_tb_sim

run: compile
	./$(SIM)

clean:
	rm -rf obj_dir

//--- tests/crt_tb.sv
module crt_tb
  import crt_host_pkg::*, crt_reg_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int H_TOTAL = 16;
  localparam int H_DISP = 12;
  localparam int H_SYNC_START = 13;
  localparam int H_SYNC_END = 15;
  localparam int V_TOTAL = 10;
  localparam int V_DISP = 8;
  localparam int V_SYNC_START = 8;
  localparam int V_SYNC_END = 9;
  localparam int FRAME = H_TOTAL * V_TOTAL;

  logic        h_hclk = 1'b0;
  logic        h_reset_n;
  crt_io_req_t req;
  logic        t_sense_n;
  logic        is01_b5;
  logic        is01_b4;
  crt_io_rsp_t rsp;
  logic        hsync;
  logic        vsync;
  logic        color_mode;

  // reference model state, as the DUT holds it after the latest edge.
  logic [5:0]  m_index;
  logic [7:0]  m_misc;
  crt_cr17_t   m_cr17;
  logic [7:0]  m_fcr;
  logic        m_int;
  int          cycles;
  logic [31:0] lfsr_state;

  crt_top #(
    .H_TOTAL(H_TOTAL), .H_DISP(H_DISP), .H_SYNC_START(H_SYNC_START),
    .H_SYNC_END(H_SYNC_END), .V_TOTAL(V_TOTAL), .V_DISP(V_DISP),
    .V_SYNC_START(V_SYNC_START), .V_SYNC_END(V_SYNC_END)
  ) UUT (
    .h_hclk(h_hclk), .h_reset_n(h_reset_n), .req(req), .t_sense_n(t_sense_n),
    .is01_b5(is01_b5), .is01_b4(is01_b4), .rsp(rsp), .hsync(hsync),
    .vsync(vsync), .color_mode(color_mode)
  );

  always #5 h_hclk = ~h_hclk;

  //////////////////////////////////////////////////
  // random source and checks
  //////////////////////////////////////////////////

  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      report_error($sformatf("mismatch at %0t: %s is %02h, expected %02h", $time, name, got, exp));
  endtask

  task automatic check_cr17(input string name, input crt_cr17_t got, input crt_cr17_t exp);
    if (got !== exp)
      report_error($sformatf("mismatch at %0t: %s is %02h, expected %02h", $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_error($sformatf("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // timing bits for raster count c, as {hsync, vsync, vsync or vde, disp_en}.
  function automatic logic [3:0] raster_at(input int c);
    int col;
    int line;
    if (c < 0) return 4'b0000;
    col = c % H_TOTAL;
    line = (c / H_TOTAL) % V_TOTAL;
    raster_at[3] = (col >= H_SYNC_START) && (col <= H_SYNC_END);
    raster_at[2] = (line >= V_SYNC_START) && (line <= V_SYNC_END);
    raster_at[1] = raster_at[2] || (line < V_DISP);
    raster_at[0] = (col < H_DISP) && (line < V_DISP);
  endfunction

  function automatic logic [15:0] port_of(input logic [3:0] offset);
    return {(m_misc[0] ? 12'h03D : 12'h03B), offset};
  endfunction

  function automatic logic [7:0] expected_read(input logic [15:0] addr);
    logic [3:0] r;
    r = raster_at(cycles - 1);
    if (addr == port_of(4'h4)) return {2'b00, m_index};
    if (addr == port_of(4'h5)) return (m_index == 6'h17) ? m_cr17 : 8'h00;
    if (addr == port_of(4'hA)) return {2'b00, is01_b5, is01_b4, r[2], 2'b00, r[0]};
    case (addr)
      16'h03CC: return m_misc;
      16'h03C2: return {m_int, 2'b00, t_sense_n, 4'b0000};
      16'h03CA: return m_fcr;
      default:  return 8'h00;
    endcase
  endfunction

  // applies the request that is present at a rising edge.
  task automatic model_edge();
    logic [3:0] r_now;
    logic [3:0] r_prev;
    r_now = raster_at(cycles - 1);
    r_prev = raster_at(cycles - 2);
    if (r_now[2] && !r_prev[2]) m_int = 1'b1;
    else if (req.rd && req.addr == 16'h03C2) m_int = 1'b0;
    if (req.wr) begin
      if (req.addr == port_of(4'h4)) begin
        m_index = req.data[5:0];
        if (req.io16 && req.data[5:0] == 6'h17) m_cr17 = crt_cr17_t'(req.data[15:8] & 8'hEF);
      end else if (req.addr == port_of(4'h5)) begin
        if (m_index == 6'h17) m_cr17 = crt_cr17_t'(req.data[7:0] & 8'hEF);
      end else if (req.addr == port_of(4'hA)) begin
        m_fcr = {4'b0000, req.data[3], 3'b000};
      end else if (req.addr == 16'h03C2) begin
        m_misc = req.data[7:0];
      end
    end
    cycles++;
  endtask

  //////////////////////////////////////////////////
  // host bus tasks
  //////////////////////////////////////////////////

  task automatic tick();
    logic [3:0] r;
    @(posedge h_hclk);
    model_edge();
    #1;
    r = raster_at(cycles - 1);
    check_bit("hsync", hsync, r[3] && m_cr17.hw_reset);
    check_bit("vsync", vsync, (m_fcr[3] ? r[1] : r[2]) && m_cr17.hw_reset);
    check_bit("color_mode", color_mode, m_misc[0]);
  endtask

  task automatic host_write(input logic [15:0] addr, input logic [15:0] data, input logic io16);
    req = '{1'b1, 1'b0, io16, addr, data};
    tick();
    req = '0;
  endtask

  task automatic host_read(input logic [15:0] addr);
    logic [7:0] exp;
    logic       is_cr17;
    int         waited;
    exp = expected_read(addr);
    is_cr17 = (addr == port_of(4'h5)) && (m_index == 6'h17);
    req = '{1'b0, 1'b1, 1'b0, addr, 16'h0000};
    tick();
    req = '0;
    waited = 0;
    while (!rsp.valid) begin
      if (waited == 20) report_error($sformatf("no read response from port %h in 20 cycles", addr));
      tick();
      waited++;
    end
    if (is_cr17) check_cr17("cr17 readback", crt_cr17_t'(rsp.data), crt_cr17_t'(exp));
    else check_byte($sformatf("rsp.data from %h", addr), rsp.data, exp);
  endtask

  task automatic wait_for_int();
    int waited;
    waited = 0;
    while (!m_int) begin
      if (waited == 2 * FRAME) report_error("retrace interrupt was not set within two frames");
      tick();
      waited++;
    end
  endtask

  task automatic random_op();
    logic [15:0] addr;
    logic [15:0] data;
    case (4'(take_bits(4)))
      4'h0, 4'h1: addr = 16'h03B4;
      4'h2, 4'h3: addr = 16'h03B5;
      4'h4:       addr = 16'h03BA;
      4'h5:       addr = 16'h03C2;
      4'h6:       addr = 16'h03CA;
      4'h7:       addr = 16'h03CC;
      4'h8, 4'h9: addr = 16'h03D4;
      4'hA, 4'hB: addr = 16'h03D5;
      4'hC:       addr = 16'h03DA;
      default:    addr = 16'h03C0;
    endcase
    data = 16'(take_bits(16));
    // the CR17 index is favoured so that mode control writes are frequent.
    if (take_bits(1) != 0) data[5:0] = 6'h17;
    t_sense_n = 1'(take_bits(1));
    is01_b5 = 1'(take_bits(1));
    is01_b4 = 1'(take_bits(1));
    if (take_bits(1) != 0) host_read(addr);
    else host_write(addr, data, 1'(take_bits(1)));
  endtask

  initial begin
    req = '0;
    t_sense_n = 1'b0;
    is01_b5 = 1'b0;
    is01_b4 = 1'b0;
    h_reset_n = 1'b0;
    m_index = '0;
    m_misc = '0;
    m_cr17 = '0;
    m_fcr = '0;
    m_int = 1'b0;
    cycles = 0;
    lfsr_state = 32'h9f1aac13;
    repeat (4) @(posedge h_hclk);
    #1;
    h_reset_n = 1'b1;
    check_bit("rsp.valid", rsp.valid, 1'b0);
    host_write(16'h03B4, 16'h0017, 1'b0);
    host_read(16'h03B5);
    host_read(16'h03CA);
    host_read(16'h03CC);
    repeat (FRAME) tick();
    // switch to color addressing and back.
    host_write(16'h03C2, 16'h0001, 1'b0);
    host_write(16'h03D4, 16'h0017, 1'b0);
    host_read(16'h03D4);
    host_read(16'h03B4);
    host_write(16'h03C2, 16'h0000, 1'b0);
    host_read(16'h03B4);
    host_write(16'h03B4, 16'h8017, 1'b1);
    repeat (FRAME) tick();
    host_write(16'h03BA, 16'h0008, 1'b0);
    repeat (FRAME) tick();
    wait_for_int();
    host_read(16'h03C2);
    host_read(16'h03C2);
    repeat (4000) begin
      random_op();
      if (take_bits(2) == 0) tick();
    end
    $display("Everything OK");
    $finish;
  end

endmodule

//--- verilog/crt_host_pkg.sv
package crt_host_pkg;

  //////////////////////////////////////////////////
  // host I/O port map
  //////////////////////////////////////////////////

  // 3C2 is the misc output register on writes and input status 0 on reads.
  typedef enum logic [15:0] {
    PORT_MONO_INDEX  = 16'h03B4,
    PORT_MONO_DATA   = 16'h03B5,
    PORT_MONO_FEAT   = 16'h03BA,
    PORT_MISC_INS0   = 16'h03C2,
    PORT_FCR_RD      = 16'h03CA,
    PORT_MISC_RD     = 16'h03CC,
    PORT_COLOR_INDEX = 16'h03D4,
    PORT_COLOR_DATA  = 16'h03D5,
    PORT_COLOR_FEAT  = 16'h03DA
  } crt_io_port_e;

  typedef struct packed {
    logic        wr;
    logic        rd;
    logic        io16;
    logic [15:0] addr;
    logic [15:0] data;
  } crt_io_req_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } crt_io_rsp_t;

  // maps a mono port to the port that is live in the current addressing mode.
  function automatic logic [15:0] active_port(input crt_io_port_e mono_port,
                                              input logic color_mode);
    crt_io_port_e color_port;
    case (mono_port)
      PORT_MONO_INDEX: color_port = PORT_COLOR_INDEX;
      PORT_MONO_DATA:  color_port = PORT_COLOR_DATA;
      default:         color_port = PORT_COLOR_FEAT;
    endcase
    return color_mode ? color_port : mono_port;
  endfunction

endpackage

//--- verilog/crt_index.sv
module crt_index
  import crt_host_pkg::*, crt_reg_pkg::*;
(
  input  logic        h_hclk,
  input  logic        h_reset_n,
  input  crt_io_req_t req,
  output crt_index_e  index,
  output logic        color_mode,
  output logic [7:0]  misc_out
);

  logic [15:0] idx_port;

  assign idx_port = active_port(PORT_MONO_INDEX, color_mode);

  // bit 0 of misc output selects the 3Dx port set.
  assign color_mode = misc_out[0];

  always_ff @(posedge h_hclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      index <= crt_index_e'(6'h00);
    end else if (req.wr && req.addr == idx_port) begin
      index <= crt_index_e'(req.data[5:0]);
    end
  end

  always_ff @(posedge h_hclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      misc_out <= 8'h00;
    end else if (req.wr && req.addr == PORT_MISC_INS0) begin
      misc_out <= req.data[7:0];
    end
  end

  //////////////////////////////////////////////////
  // bus protocol
  //////////////////////////////////////////////////

  // the write decode here and the read decode in the read mux assume
  // a request is never both.
  a_no_wr_rd: assert property (@(posedge h_hclk) disable iff (!h_reset_n)
    !(req.wr && req.rd))
    else $error("host request has wr and rd set together");

endmodule

//--- verilog/crt_misc.sv
module crt_misc
  import crt_host_pkg::*, crt_reg_pkg::*;
(
  input  logic        h_hclk,
  input  logic        h_reset_n,
  input  crt_io_req_t req,
  input  crt_index_e  index,
  input  logic        color_mode,
  input  crt_sync_t   sync,
  input  logic        t_sense_n,
  input  logic        is01_b5,
  input  logic        is01_b4,
  output crt_cr17_t   cr17,
  output logic [7:0]  reg_fcr,
  output logic [7:0]  reg_ins0,
  output logic [7:0]  reg_ins1,
  output logic        vsync_sel
);

  logic [15:0] idx_port;
  logic [15:0] data_port;
  logic [15:0] feat_port;
  logic        cr17_wr;
  logic [7:0]  cr17_byte;
  logic        fcr_vsel;

  assign idx_port  = active_port(PORT_MONO_INDEX, color_mode);
  assign data_port = active_port(PORT_MONO_DATA, color_mode);
  assign feat_port = active_port(PORT_MONO_FEAT, color_mode);

  // a 16-bit index write carries the new index in the low byte and the
  // register data in the high byte.
  always_comb begin
    cr17_wr   = 1'b0;
    cr17_byte = req.data[7:0];
    if (req.wr) begin
      if (req.addr == data_port && index == CR17_MODE) begin
        cr17_wr = 1'b1;
      end else if (req.addr == idx_port && req.io16 && req.data[5:0] == CR17_MODE) begin
        cr17_wr   = 1'b1;
        cr17_byte = req.data[15:8];
      end
    end
  end

  always_ff @(posedge h_hclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      cr17 <= '0;
    end else if (cr17_wr) begin
      cr17 <= cr17_from_byte(cr17_byte);
    end
  end

  // only the vsync select bit of feature control is kept.
  always_ff @(posedge h_hclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      fcr_vsel <= 1'b0;
    end else if (req.wr && req.addr == feat_port) begin
      fcr_vsel <= req.data[3];
    end
  end

  //////////////////////////////////////////////////
  // status bytes
  //////////////////////////////////////////////////

  assign reg_fcr   = {4'b0000, fcr_vsel, 3'b000};
  assign vsync_sel = fcr_vsel;
  assign reg_ins0  = {sync.crt_int, 2'b00, t_sense_n, 4'b0000};
  assign reg_ins1  = {2'b00, is01_b5, is01_b4, sync.raw_vsync, 2'b00, sync.disp_en};

  a_cr17_zero: assert property (@(posedge h_hclk) disable iff (!h_reset_n)
    cr17.zero == 1'b0)
    else $error("CR17 bit 4 is set");

endmodule

//--- verilog/crt_read_mux.sv
module crt_read_mux
  import crt_host_pkg::*, crt_reg_pkg::*;
(
  input  logic        h_hclk,
  input  logic        h_reset_n,
  input  crt_io_req_t req,
  input  crt_index_e  index,
  input  logic        color_mode,
  input  logic [7:0]  misc_out,
  input  crt_cr17_t   cr17,
  input  logic [7:0]  reg_fcr,
  input  logic [7:0]  reg_ins0,
  input  logic [7:0]  reg_ins1,
  output crt_io_rsp_t rsp,
  output logic        int_clr
);

  logic [15:0] idx_port;
  logic [15:0] data_port;
  logic [15:0] feat_port;
  logic [7:0]  rd_byte;

  assign idx_port  = active_port(PORT_MONO_INDEX, color_mode);
  assign data_port = active_port(PORT_MONO_DATA, color_mode);
  assign feat_port = active_port(PORT_MONO_FEAT, color_mode);

  // ports of the inactive mode fall through to the default and read as 0.
  always_comb begin
    rd_byte = 8'h00;
    if (req.addr == idx_port) begin
      rd_byte = {2'b00, index};
    end else if (req.addr == data_port) begin
      rd_byte = (index == CR17_MODE) ? cr17 : 8'h00;
    end else if (req.addr == feat_port) begin
      rd_byte = reg_ins1;
    end else begin
      case (req.addr)
        PORT_MISC_RD:   rd_byte = misc_out;
        PORT_MISC_INS0: rd_byte = reg_ins0;
        PORT_FCR_RD:    rd_byte = reg_fcr;
        default:        rd_byte = 8'h00;
      endcase
    end
  end

  // reading status 0 acknowledges the retrace interrupt.
  assign int_clr = req.rd && (req.addr == PORT_MISC_INS0);

  always_ff @(posedge h_hclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      rsp <= '0;
    end else begin
      rsp.valid <= req.rd;
      if (req.rd) begin
        rsp.data <= rd_byte;
      end
    end
  end

endmodule

//--- verilog/crt_reg_pkg.sv
package crt_reg_pkg;

  //////////////////////////////////////////////////
  // CRTC register layout
  //////////////////////////////////////////////////

  // only the mode control register is implemented, the rest read as zero.
  typedef enum logic [5:0] {
    CR17_MODE = 6'h17
  } crt_index_e;

  // CR17 mode control, most significant bit first.
  typedef struct packed {
    logic hw_reset;
    logic word_byte;
    logic addr_wrap;
    logic zero;
    logic count_by2;
    logic hscan_by2;
    logic map14;
    logic map13;
  } crt_cr17_t;

  // raster status as seen by the status registers.
  typedef struct packed {
    logic raw_vsync;
    logic vsync_vde;
    logic disp_en;
    logic crt_int;
  } crt_sync_t;

  // builds a CR17 value from a host byte with the reserved bit held low.
  function automatic crt_cr17_t cr17_from_byte(input logic [7:0] wdata);
    crt_cr17_t val;
    val = crt_cr17_t'(wdata);
    val.zero = 1'b0;
    return val;
  endfunction

endpackage

//--- verilog/crt_sync_gen.sv
module crt_sync_gen
  import crt_reg_pkg::*;
#(
  parameter int unsigned H_TOTAL      = 16,
  parameter int unsigned H_DISP       = 12,
  parameter int unsigned H_SYNC_START = 13,
  parameter int unsigned H_SYNC_END   = 15,
  parameter int unsigned V_TOTAL      = 10,
  parameter int unsigned V_DISP       = 8,
  parameter int unsigned V_SYNC_START = 8,
  parameter int unsigned V_SYNC_END   = 9
) (
  input  logic      h_hclk,
  input  logic      h_reset_n,
  input  crt_cr17_t cr17,
  input  logic      vsync_sel,
  input  logic      int_clr,
  output crt_sync_t sync,
  output logic      hsync,
  output logic      vsync
);

  localparam int HW = (H_TOTAL > 1) ? $clog2(H_TOTAL) : 1;
  localparam int VW = (V_TOTAL > 1) ? $clog2(V_TOTAL) : 1;

  logic [HW-1:0] col;
  logic [VW-1:0] line;
  logic          col_last;
  logic          line_last;
  logic          hsync_r;
  logic          vsync_d;
  logic          vsync_rise;
  logic          h_in_sync;
  logic          v_in_sync;

  //////////////////////////////////////////////////
  // raster counters
  //////////////////////////////////////////////////

  assign col_last  = (col == HW'(H_TOTAL - 1));
  assign line_last = (line == VW'(V_TOTAL - 1));

  always_ff @(posedge h_hclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      col  <= '0;
      line <= '0;
    end else if (col_last) begin
      col  <= '0;
      line <= line_last ? '0 : line + 1'b1;
    end else begin
      col <= col + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // registered timing signals
  //////////////////////////////////////////////////

  assign h_in_sync = (col >= HW'(H_SYNC_START)) && (col <= HW'(H_SYNC_END));
  assign v_in_sync = (line >= VW'(V_SYNC_START)) && (line <= VW'(V_SYNC_END));

  always_ff @(posedge h_hclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      hsync_r        <= 1'b0;
      sync.raw_vsync <= 1'b0;
      sync.vsync_vde <= 1'b0;
      sync.disp_en   <= 1'b0;
      vsync_d        <= 1'b0;
    end else begin
      hsync_r        <= h_in_sync;
      sync.raw_vsync <= v_in_sync;
      sync.vsync_vde <= v_in_sync || (line < VW'(V_DISP));
      sync.disp_en   <= (col < HW'(H_DISP)) && (line < VW'(V_DISP));
      vsync_d        <= sync.raw_vsync;
    end
  end

  assign vsync_rise = sync.raw_vsync && !vsync_d;

  // a new vsync start wins over a status 0 read in the same cycle, so no
  // retrace event is lost.
  always_ff @(posedge h_hclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      sync.crt_int <= 1'b0;
    end else if (vsync_rise) begin
      sync.crt_int <= 1'b1;
    end else if (int_clr) begin
      sync.crt_int <= 1'b0;
    end
  end

  // sync outputs are held inactive until CR17 bit 7 is set.
  assign hsync = hsync_r && cr17.hw_reset;
  assign vsync = (vsync_sel ? sync.vsync_vde : sync.raw_vsync) && cr17.hw_reset;

  a_col_range: assert property (@(posedge h_hclk) disable iff (!h_reset_n)
    col < HW'(H_TOTAL) || H_TOTAL == (1 << HW))
    else $error("column counter out of range");

  a_line_range: assert property (@(posedge h_hclk) disable iff (!h_reset_n)
    line < VW'(V_TOTAL) || V_TOTAL == (1 << VW))
    else $error("line counter out of range");

endmodule

//--- verilog/crt_top.sv
module crt_top
  import crt_host_pkg::*, crt_reg_pkg::*;
#(
  parameter int unsigned H_TOTAL      = 16,
  parameter int unsigned H_DISP       = 12,
  parameter int unsigned H_SYNC_START = 13,
  parameter int unsigned H_SYNC_END   = 15,
  parameter int unsigned V_TOTAL      = 10,
  parameter int unsigned V_DISP       = 8,
  parameter int unsigned V_SYNC_START = 8,
  parameter int unsigned V_SYNC_END   = 9
) (
  input  logic        h_hclk,
  input  logic        h_reset_n,
  input  crt_io_req_t req,
  input  logic        t_sense_n,
  input  logic        is01_b5,
  input  logic        is01_b4,
  output crt_io_rsp_t rsp,
  output logic        hsync,
  output logic        vsync,
  output logic        color_mode
);

  crt_index_e index;
  logic [7:0] misc_out;
  crt_cr17_t  cr17;
  logic [7:0] reg_fcr;
  logic [7:0] reg_ins0;
  logic [7:0] reg_ins1;
  logic       vsync_sel;
  logic       int_clr;
  crt_sync_t  sync;

  crt_index u_index (
    .h_hclk(h_hclk), .h_reset_n(h_reset_n), .req(req),
    .index(index), .color_mode(color_mode), .misc_out(misc_out)
  );

  crt_misc u_misc (
    .h_hclk(h_hclk), .h_reset_n(h_reset_n), .req(req), .index(index),
    .color_mode(color_mode), .sync(sync), .t_sense_n(t_sense_n),
    .is01_b5(is01_b5), .is01_b4(is01_b4), .cr17(cr17), .reg_fcr(reg_fcr),
    .reg_ins0(reg_ins0), .reg_ins1(reg_ins1), .vsync_sel(vsync_sel)
  );

  crt_sync_gen #(
    .H_TOTAL(H_TOTAL), .H_DISP(H_DISP),
    .H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
    .V_TOTAL(V_TOTAL), .V_DISP(V_DISP),
    .V_SYNC_START(V_SYNC_START), .V_SYNC_END(V_SYNC_END)
  ) u_sync_gen (
    .h_hclk(h_hclk), .h_reset_n(h_reset_n), .cr17(cr17), .vsync_sel(vsync_sel),
    .int_clr(int_clr), .sync(sync), .hsync(hsync), .vsync(vsync)
  );

  crt_read_mux u_read_mux (
    .h_hclk(h_hclk), .h_reset_n(h_reset_n), .req(req), .index(index),
    .color_mode(color_mode), .misc_out(misc_out), .cr17(cr17), .reg_fcr(reg_fcr),
    .reg_ins0(reg_ins0), .reg_ins1(reg_ins1), .rsp(rsp), .int_clr(int_clr)
  );

endmodule

//--- vga_crt.f
verilog/crt_host_pkg.sv
verilog/crt_reg_pkg.sv
verilog/crt_index.sv
verilog/crt_misc.sv
verilog/crt_sync_gen.sv
verilog/crt_read_mux.sv
verilog/crt_top.sv
tests/crt_tb.sv
